//--- uart_prog_ram.f
+incdir+common
common/prog_ram_pkg.sv
logic/uart_rx.sv
loader/prog_loader.sv
ram/byte_ram.sv
logic/prog_ram_top.sv
test/tb_prog_ram.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_prog_ram
FILELIST  := uart_prog_ram.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Finished with no errors

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_prog_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "prog_ram_defines.svh"

module tb_prog_ram import prog_ram_pkg::*; ();

  localparam int CLK_PERIOD  = 8;
  localparam int BIT_CYCLES  = `UPR_BAUD_DIV;
  localparam int KEY_W       = `UPR_KEY_LEN * 8;
  // Serial bytes over all tests, ten bits per frame
  localparam int TOTAL_BYTES = 112;
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 10 * BIT_CYCLES + `UPR_GAP_LIMIT + 3000;
  localparam logic [KEY_W-1:0] KEY = `UPR_KEY;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   rx_i;
  ram_wr_req_t            host_req;
  logic [`UPR_ADDR_W-1:0] rd_addr;
  logic                   rd_en;
  ram_word_u              rd_data;
  logic                   prog_mode;
  logic                   sys_rst_n;

  logic [`UPR_DATA_W-1:0] model [`UPR_RAM_DEPTH];
  integer                 seed;
  int                     errors = 0;
  int                     checks = 0;
  int                     rst_pulses = 0;
  int                     mode_rises = 0;
  logic                   mode_prev = 1'b0;

  prog_ram_top i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_i        (rx_i),
    .host_req_i  (host_req),
    .rd_addr_i   (rd_addr),
    .rd_en_i     (rd_en),
    .rd_data_o   (rd_data),
    .prog_mode_o (prog_mode),
    .sys_rst_no  (sys_rst_n)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!sys_rst_n) begin
        rst_pulses++;
      end
      if (prog_mode && !mode_prev) begin
        mode_rises++;
      end
      mode_prev = prog_mode;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at time %0t: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at time %0t: %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  // Start bit, eight data bits LSB first, stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_i = frame[i];
      repeat (BIT_CYCLES) @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 3; i >= 0; i--) begin
      send_byte(w[8*i +: 8]);
    end
  endtask

  task automatic send_key(input logic [KEY_W-1:0] key);
    for (int i = `UPR_KEY_LEN - 1; i >= 0; i--) begin
      send_byte(key[8*i +: 8]);
    end
  endtask

  task automatic host_write(input int addr, input logic [31:0] data, input logic [3:0] strb);
    host_req.addr      = `UPR_ADDR_W'(addr);
    host_req.data.word = data;
    host_req.strb      = strb;
    @(posedge clk_i);
    #1;
    host_req.strb = '0;
    for (int b = 0; b < `UPR_NB_BYTES; b++) begin
      if (strb[b]) begin
        model[addr][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // Data is due one cycle after rd_en and must hold afterwards
  task automatic read_check(input int addr);
    rd_addr = `UPR_ADDR_W'(addr);
    rd_en   = 1'b1;
    @(posedge clk_i);
    #1;
    rd_en = 1'b0;
    check_word($sformatf("rd_data_o[%0d]", addr), rd_data.word, model[addr]);
    rd_addr = `UPR_ADDR_W'(addr + 1);
    @(posedge clk_i);
    #1;
    check_word($sformatf("rd_data_o[%0d] held", addr), rd_data.word, model[addr]);
  endtask

  task automatic read_range(input int first, input int last);
    for (int a = first; a <= last; a++) begin
      read_check(a);
    end
  endtask

  task automatic wait_reset_pulse();
    int cycles;
    cycles = 0;
    while (rst_pulses == 0 && cycles < 400) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    check_true(rst_pulses != 0, "sys_rst_no never pulsed low after the load");
    repeat (4) @(posedge clk_i);
    #1;
  endtask

  // Key, count and n random words, loaded from address 0
  task automatic load_words(input int n);
    logic [31:0] w;
    rst_pulses = 0;
    mode_rises = 0;
    send_key(KEY);
    send_word(n);
    for (int i = 0; i < n; i++) begin
      w = $random(seed);
      model[i] = w;
      send_word(w);
    end
    wait_reset_pulse();
    check_word("sys_rst_no low cycles", rst_pulses, 1);
    check_word("prog_mode_o rises", mode_rises, (n > 0) ? 1 : 0);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic host_strobe_test();
    host_write(100, 32'h11223344, 4'hf);
    host_write(101, 32'h55667788, 4'hf);
    host_write(100, $random(seed), 4'b0101);
    host_write(101, $random(seed), 4'b1000);
    host_write(102, $random(seed), 4'b0110);
    host_write(103, $random(seed), 4'b0011);
    // No strobe, no write
    host_write(103, $random(seed), 4'b0000);
    read_range(100, 103);
  endtask

  task automatic wrong_key_test();
    rst_pulses = 0;
    mode_rises = 0;
    send_key(KEY ^ KEY_W'(1));
    send_word(32'd1);
    send_word($random(seed));
    repeat (40) @(posedge clk_i);
    #1;
    check_word("sys_rst_no low cycles", rst_pulses, 0);
    check_word("prog_mode_o rises", mode_rises, 0);
    read_range(0, 5);
    read_range(100, 103);
  endtask

  task automatic gap_timeout_test();
    for (int i = `UPR_KEY_LEN - 1; i >= `UPR_KEY_LEN / 2; i--) begin
      send_byte(KEY[8*i +: 8]);
    end
    repeat (`UPR_GAP_LIMIT + 50) @(posedge clk_i);
    #1;
    load_words(2);
    read_range(0, 5);
  endtask

  initial begin
    seed     = 32'h4fa2;
    rst_ni   = 1'b0;
    rx_i     = 1'b1;
    host_req = '0;
    rd_addr  = '0;
    rd_en    = 1'b0;
    for (int i = 0; i < `UPR_RAM_DEPTH; i++) begin
      model[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_word("prog_mode_o", prog_mode, 0);
    check_word("sys_rst_no", sys_rst_n, 1);
    check_word("rd_data_o", rd_data.word, 0);

    host_strobe_test();
    load_words(6);
    read_range(0, 5);
    wrong_key_test();
    gap_timeout_test();
    // Second load rewinds to address 0
    load_words(3);
    read_range(0, 5);
    load_words(0);
    read_range(0, 5);
    read_range(100, 103);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/prog_ram_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "prog_ram_defines.svh"

module prog_ram_top import prog_ram_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rx_i,
  input  ram_wr_req_t            host_req_i,
  input  logic [`UPR_ADDR_W-1:0] rd_addr_i,
  input  logic                   rd_en_i,
  output ram_word_u              rd_data_o,
  output logic                   prog_mode_o,
  output logic                   sys_rst_no
);

  logic [7:0]  rx_byte;
  logic        rx_valid;
  ram_wr_req_t prog_req;
  logic        prog_we;

  // Serial line to bytes
  uart_rx i_uart_rx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_i       (rx_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid)
  );

  // Key check and word assembly
  prog_loader i_prog_loader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_byte_i   (rx_byte),
    .rx_valid_i  (rx_valid),
    .prog_req_o  (prog_req),
    .prog_we_o   (prog_we),
    .prog_mode_o (prog_mode_o),
    .sys_rst_no  (sys_rst_no)
  );

  byte_ram i_byte_ram (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .host_req_i (host_req_i),
    .prog_req_i (prog_req),
    .prog_we_i  (prog_we),
    .rd_addr_i  (rd_addr_i),
    .rd_en_i    (rd_en_i),
    .rd_data_o  (rd_data_o)
  );

endmodule

`default_nettype wire

//--- ram/byte_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "prog_ram_defines.svh"

module byte_ram import prog_ram_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ram_wr_req_t            host_req_i,
  input  ram_wr_req_t            prog_req_i,
  input  logic                   prog_we_i,
  input  logic [`UPR_ADDR_W-1:0] rd_addr_i,
  input  logic                   rd_en_i,
  output ram_word_u              rd_data_o
);

  ram_word_u   mem [`UPR_RAM_DEPTH];
  ram_wr_req_t wr_req;

  // Loader word wins over a host write in the same cycle
  assign wr_req = prog_we_i ? prog_req_i : host_req_i;

  initial begin
    for (int i = 0; i < `UPR_RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Loader requests carry all strobes, host strobes pick lanes
  always @(posedge clk_i) begin
    for (int b = 0; b < `UPR_NB_BYTES; b++) begin
      if (wr_req.strb[b]) begin
        mem[wr_req.addr].bytes[b] <= wr_req.data.bytes[b];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_data_o <= '0;
    end else if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

//--- loader/prog_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "prog_ram_defines.svh"

module prog_loader import prog_ram_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [7:0]  rx_byte_i,
  input  logic        rx_valid_i,
  output ram_wr_req_t prog_req_o,
  output logic        prog_we_o,
  output logic        prog_mode_o,
  output logic        sys_rst_no
);

  localparam int KEY_W     = `UPR_KEY_LEN * 8;
  localparam int KEY_CNT_W = $clog2(`UPR_KEY_LEN);
  localparam int GAP_W     = $clog2(`UPR_GAP_LIMIT);
  localparam int BYTE_W    = $clog2(`UPR_NB_BYTES);

  localparam logic [KEY_W-1:0]     KEY       = `UPR_KEY;
  localparam logic [KEY_CNT_W-1:0] KEY_LAST  = KEY_CNT_W'(`UPR_KEY_LEN - 1);
  localparam logic [GAP_W-1:0]     GAP_LAST  = GAP_W'(`UPR_GAP_LIMIT - 1);
  localparam logic [BYTE_W-1:0]    BYTE_LAST = BYTE_W'(`UPR_NB_BYTES - 1);

  localparam logic [2:0] ST_WAIT    = 3'd0;
  localparam logic [2:0] ST_RECEIVE = 3'd1;
  localparam logic [2:0] ST_CHECK   = 3'd2;
  localparam logic [2:0] ST_COUNT   = 3'd3;
  localparam logic [2:0] ST_PROGRAM = 3'd4;
  localparam logic [2:0] ST_FINISH  = 3'd5;

  logic [2:0]             state_q;
  logic [KEY_W-1:0]       key_q;
  logic [KEY_CNT_W-1:0]   key_cnt_q;
  logic [GAP_W-1:0]       gap_cnt_q;
  logic [BYTE_W-1:0]      byte_cnt_q;
  logic [`UPR_DATA_W-1:0] word_count_q;
  logic [`UPR_DATA_W-1:0] wr_count_q;
  logic [`UPR_DATA_W-1:0] count_next;
  logic [`UPR_ADDR_W-1:0] load_addr_q;
  ram_word_u              word_q;
  logic                   prog_we_q;

  // Count is sent MSB first like the words
  assign count_next = {word_count_q[`UPR_DATA_W-9:0], rx_byte_i};

  assign prog_req_o  = '{addr: load_addr_q, data: word_q, strb: {`UPR_NB_BYTES{1'b1}}};
  assign prog_we_o   = prog_we_q;
  assign prog_mode_o = (state_q == ST_PROGRAM);
  assign sys_rst_no  = (state_q != ST_FINISH);

  ////////////////////////////////////////////////////////////
  // Byte shifters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      if (state_q == ST_WAIT || state_q == ST_RECEIVE) begin
        key_q <= {key_q[KEY_W-9:0], rx_byte_i};
      end
      if (state_q == ST_COUNT) begin
        word_count_q <= count_next;
      end
      if (state_q == ST_PROGRAM) begin
        word_q.bytes <= {word_q.bytes[`UPR_NB_BYTES-2:0], rx_byte_i};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequence FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= ST_WAIT;
      key_cnt_q   <= '0;
      gap_cnt_q   <= '0;
      byte_cnt_q  <= '0;
      wr_count_q  <= '0;
      load_addr_q <= '0;
      prog_we_q   <= 1'b0;
    end else begin
      prog_we_q <= 1'b0;

      // Address moves on once the word is in the RAM
      if (prog_we_q) begin
        load_addr_q <= load_addr_q + 1'b1;
        wr_count_q  <= wr_count_q + 1'b1;
      end

      case (state_q)
        ST_WAIT: begin
          gap_cnt_q <= '0;
          if (rx_valid_i) begin
            key_cnt_q <= KEY_CNT_W'(1);
            state_q   <= ST_RECEIVE;
          end
        end
        ST_RECEIVE: begin
          if (rx_valid_i) begin
            gap_cnt_q <= '0;
            key_cnt_q <= key_cnt_q + 1'b1;
            if (key_cnt_q == KEY_LAST) begin
              state_q <= ST_CHECK;
            end
          end else if (gap_cnt_q == GAP_LAST) begin
            // Line went quiet in the middle of the key
            state_q <= ST_WAIT;
          end else begin
            gap_cnt_q <= gap_cnt_q + 1'b1;
          end
        end
        ST_CHECK: begin
          byte_cnt_q <= '0;
          wr_count_q <= '0;
          state_q    <= (key_q == KEY) ? ST_COUNT : ST_WAIT;
        end
        ST_COUNT: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == BYTE_LAST) begin
              // Empty load skips straight to the reset pulse
              state_q <= (count_next == '0) ? ST_FINISH : ST_PROGRAM;
            end
          end
        end
        ST_PROGRAM: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == BYTE_LAST) begin
              prog_we_q <= 1'b1;
            end
          end
          if (wr_count_q == word_count_q) begin
            state_q <= ST_FINISH;
          end
        end
        default: begin
          state_q <= ST_WAIT;
        end
      endcase

      // System reset also rewinds the load address
      if (!sys_rst_no) begin
        load_addr_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "prog_ram_defines.svh"

module uart_rx (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rx_i,
  output logic [7:0] rx_byte_o,
  output logic       rx_valid_o
);

  localparam int CNT_W = $clog2(`UPR_BAUD_DIV);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(`UPR_BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`UPR_BAUD_DIV / 2 - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic [1:0]       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic             rx_q1;
  logic             rx_q2;
  logic [7:0]       shift_q;

  // Byte stays in the shifter until the next data bit
  assign rx_byte_o = shift_q;

  // Two sync flops that reset to the idle high level
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_q1 <= 1'b1;
      rx_q2 <= 1'b1;
    end else begin
      rx_q1 <= rx_i;
      rx_q2 <= rx_q1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_DATA && cnt_q == BIT_END) begin
      // LSB arrives first
      shift_q <= {rx_q2, shift_q[7:1]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      cnt_q      <= cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (!rx_q2) begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          // Mid-bit check rejects short glitches
          if (cnt_q == HALF_END) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_q2 ? ST_IDLE : ST_DATA;
          end
        end
        ST_DATA: begin
          if (cnt_q == BIT_END) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= ST_STOP;
            end
          end
        end
        default: begin
          // A low line at mid stop bit drops the byte
          if (cnt_q == BIT_END) begin
            rx_valid_o <= rx_q2;
            state_q    <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- common/prog_ram_pkg.sv
`default_nettype none

`include "prog_ram_defines.svh"

package prog_ram_pkg;

  ////////////////////////////////////////////////////////////
  // RAM word
  ////////////////////////////////////////////////////////////

  // Whole word or byte lanes, bytes[NB_BYTES-1] is the most significant
  typedef union packed {
    logic [`UPR_DATA_W-1:0]        word;
    logic [`UPR_NB_BYTES-1:0][7:0] bytes;
  } ram_word_u;

  ////////////////////////////////////////////////////////////
  // Write request
  ////////////////////////////////////////////////////////////

  // Shared by the host port and the loader port
  typedef struct packed {
    logic [`UPR_ADDR_W-1:0]   addr;
    ram_word_u                data;
    logic [`UPR_NB_BYTES-1:0] strb;
  } ram_wr_req_t;

endpackage

`default_nettype wire

//--- common/prog_ram_defines.svh
`ifndef PROG_RAM_DEFINES_SVH
`define PROG_RAM_DEFINES_SVH

////////////////////////////////////////////////////////////
// RAM geometry
////////////////////////////////////////////////////////////

`define UPR_RAM_DEPTH 1024
`define UPR_ADDR_W 10
`define UPR_DATA_W 32
`define UPR_NB_BYTES 4

////////////////////////////////////////////////////////////
// Serial loader
////////////////////////////////////////////////////////////

// Clock cycles per serial bit, small for simulation
`define UPR_BAUD_DIV 16

// Key that opens a load, sent first byte first
`define UPR_KEY "LOADPROG"
`define UPR_KEY_LEN 8

// Idle cycles tolerated between two key bytes
`define UPR_GAP_LIMIT 4000

`endif
